// File: board_pkg.sv
////////////////////
// Shared widths, joystick types, status bit positions,
// aspect values and the colour widening function
////////////////////
package board_pkg;

    // Player count and joystick widths
    localparam int NUM_PLAYERS = 4;
    localparam int BOARD_JOYW  = 16;
    localparam int JOYW        = 10;

    typedef logic [BOARD_JOYW-1:0] board_joy_t;
    typedef logic [JOYW-1:0]       game_joy_t;
    typedef logic [1:0]            rotate_t;
    typedef logic [1:0]            fx_t;
    typedef logic [11:0]           aspect_t;

    // Buttons above the game field of a board joystick
    localparam int JOY_START_BIT   = 10;
    localparam int JOY_COIN_BIT    = 11;
    // Player 1 only
    localparam int JOY_SERVICE_BIT = 12;
    localparam int JOY_RESET_BIT   = 13;
    localparam int JOY_PAUSE_BIT   = 14;

    // OSD status word
    localparam int ST_ASPECT  = 1;
    localparam int ST_ROTATE  = 2;
    localparam int ST_FX_LO   = 3;   // effect level spans bits 4:3
    localparam int ST_FM_OFF  = 6;
    localparam int ST_PSG_OFF = 7;
    localparam int ST_TEST    = 10;
    localparam int ST_PAUSE   = 12;
    localparam int ST_FLIP    = 13;

    // HDMI aspect ratio terms
    localparam aspect_t ASPECT_WIDE_X = 12'd16;
    localparam aspect_t ASPECT_WIDE_Y = 12'd9;
    localparam aspect_t ASPECT_H_X    = 12'd4;
    localparam aspect_t ASPECT_H_Y    = 12'd3;
    localparam aspect_t ASPECT_V_X    = 12'd3;
    localparam aspect_t ASPECT_V_Y    = 12'd4;

    // Widen a w-bit channel, held in the low bits of c, to 8 bits.
    // The MSBs are repeated below the value to fill the LSBs.
    function automatic logic [7:0] color_extend8(input logic [7:0] c, input int w);
        logic [7:0] ext;
        for (int i = 0; i < 8; i++) begin
            ext[7-i] = c[w-1-(i%w)];
        end
        return ext;
    endfunction

endpackage

// File: board_reset.sv
////////////////////
// Global reset synchronizer and game reset stretcher
////////////////////
`timescale 1ns/1ps

module board_reset #(
    parameter int GAME_RST_HOLD = 16
) (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    input  logic dip_flip,
    output logic sys_rst_n,
    output logic game_rst_n
);
    localparam int CNTW = GAME_RST_HOLD > 1 ? $clog2(GAME_RST_HOLD) : 1;
    localparam logic [CNTW-1:0] HOLD_LOAD = CNTW'(GAME_RST_HOLD - 1);

    logic [1:0]      rst_sync;
    logic            flip_l;
    logic            cause;
    logic [CNTW-1:0] hold_cnt;

    // Two flops align the release with clk_sys
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign sys_rst_n = rst_sync[1];

    // A flip change restarts the game as the screen layout changes
    assign cause = !sys_rst_n || downloading || rst_req || soft_rst || (dip_flip != flip_l);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            flip_l     <= 1'b0;
            hold_cnt   <= HOLD_LOAD;
            game_rst_n <= 1'b0;
        end else begin
            flip_l <= dip_flip;
            if (cause) begin
                hold_cnt <= HOLD_LOAD;
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            game_rst_n <= !cause && (hold_cnt == '0);
        end
    end

    a_no_game_during_download: assert property (
        @(posedge clk_sys) disable iff (!rst_n) downloading |=> !game_rst_n);

endmodule

// File: board_inputs.sv
////////////////////
// Board to game joystick mapping, coins, starts, service,
// soft reset and pause toggle, locked during downloads
////////////////////
`timescale 1ns/1ps

module board_inputs #(
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic                            clk_sys,
    input  logic                            sys_rst_n,
    input  logic                            downloading,
    input  board_pkg::board_joy_t           board_joystick1,
    input  board_pkg::board_joy_t           board_joystick2,
    input  board_pkg::board_joy_t           board_joystick3,
    input  board_pkg::board_joy_t           board_joystick4,
    output board_pkg::game_joy_t            game_joystick1,
    output board_pkg::game_joy_t            game_joystick2,
    output board_pkg::game_joy_t            game_joystick3,
    output board_pkg::game_joy_t            game_joystick4,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_coin,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_start,
    output logic                            game_service,
    output logic                            soft_rst,
    output logic                            game_pause
);
    import board_pkg::*;

    // Idle level of the game side
    localparam game_joy_t JOY_IDLE = {JOYW{GAME_INPUTS_ACTIVE_LOW}};
    localparam logic [NUM_PLAYERS-1:0] BTN_IDLE = {NUM_PLAYERS{GAME_INPUTS_ACTIVE_LOW}};

    board_joy_t             board_joy [NUM_PLAYERS];
    board_joy_t             joy_lock  [NUM_PLAYERS];
    game_joy_t              joy_q     [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] coin_raw;
    logic [NUM_PLAYERS-1:0] start_raw;
    logic                   rst_btn;
    logic                   rst_btn_l;
    logic                   pause_btn;
    logic                   pause_btn_l;

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    // Downloads mask every button, so no edge is seen either
    always_comb begin
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            joy_lock[i]  = downloading ? '0 : board_joy[i];
            coin_raw[i]  = joy_lock[i][JOY_COIN_BIT];
            start_raw[i] = joy_lock[i][JOY_START_BIT];
        end
    end

    assign rst_btn   = joy_lock[0][JOY_RESET_BIT];
    assign pause_btn = joy_lock[0][JOY_PAUSE_BIT];

    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                joy_q[i] <= JOY_IDLE;
            end
            game_coin    <= BTN_IDLE;
            game_start   <= BTN_IDLE;
            game_service <= GAME_INPUTS_ACTIVE_LOW;
            rst_btn_l    <= 1'b0;
            pause_btn_l  <= 1'b0;
            soft_rst     <= 1'b0;
            game_pause   <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                joy_q[i] <= joy_lock[i][JOYW-1:0] ^ JOY_IDLE;
            end
            game_coin    <= coin_raw ^ BTN_IDLE;
            game_start   <= start_raw ^ BTN_IDLE;
            game_service <= joy_lock[0][JOY_SERVICE_BIT] ^ GAME_INPUTS_ACTIVE_LOW;
            rst_btn_l    <= rst_btn;
            pause_btn_l  <= pause_btn;
            soft_rst     <= rst_btn & ~rst_btn_l;
            if (pause_btn && !pause_btn_l) begin
                game_pause <= ~game_pause;
            end
        end
    end

    assign game_joystick1 = joy_q[0];
    assign game_joystick2 = joy_q[1];
    assign game_joystick3 = joy_q[2];
    assign game_joystick4 = joy_q[3];

    a_soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (!sys_rst_n) soft_rst |=> !soft_rst);

endmodule

// File: board_dip.sv
////////////////////
// OSD status word decoder for display, sound and game switches
////////////////////
`timescale 1ns/1ps

module board_dip (
    input  logic                 clk_sys,
    input  logic                 sys_rst_n,
    input  logic [31:0]          status,
    input  logic [6:0]           core_mod,
    input  logic                 game_pause,
    output board_pkg::rotate_t   rotate,
    output board_pkg::aspect_t   hdmi_arx,
    output board_pkg::aspect_t   hdmi_ary,
    output logic                 enable_fm,
    output logic                 enable_psg,
    output logic                 dip_test,
    output logic                 dip_pause,
    output logic                 dip_flip,
    output board_pkg::fx_t       dip_fxlevel
);
    import board_pkg::*;

    logic    tate;
    logic    rot_ctrl;
    aspect_t arx_nxt;
    aspect_t ary_nxt;

    // Vertical game flag from the core
    assign tate     = core_mod[0];
    assign rot_ctrl = status[ST_ROTATE];

    always_comb begin
        if (status[ST_ASPECT]) begin
            arx_nxt = ASPECT_WIDE_X;
            ary_nxt = ASPECT_WIDE_Y;
        end else if (tate && !rot_ctrl) begin
            // Unrotated vertical screen
            arx_nxt = ASPECT_V_X;
            ary_nxt = ASPECT_V_Y;
        end else begin
            arx_nxt = ASPECT_H_X;
            ary_nxt = ASPECT_H_Y;
        end
    end

    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rotate      <= '0;
            hdmi_arx    <= '0;
            hdmi_ary    <= '0;
            enable_fm   <= 1'b0;
            enable_psg  <= 1'b0;
            dip_test    <= 1'b0;
            dip_pause   <= 1'b0;
            dip_flip    <= 1'b0;
            dip_fxlevel <= '0;
        end else begin
            rotate      <= {status[ST_FLIP], rot_ctrl & tate};
            hdmi_arx    <= arx_nxt;
            hdmi_ary    <= ary_nxt;
            enable_fm   <= ~status[ST_FM_OFF];
            enable_psg  <= ~status[ST_PSG_OFF];
            dip_test    <= status[ST_TEST];
            dip_pause   <= status[ST_PAUSE] | game_pause;
            dip_flip    <= status[ST_FLIP];
            dip_fxlevel <= status[ST_FX_LO +: $bits(fx_t)];
        end
    end

endmodule

// File: board_led.sv
////////////////////
// Status LED with download blink
////////////////////
`timescale 1ns/1ps

module board_led (
    input  logic       clk_sys,
    input  logic       sys_rst_n,
    input  logic       LVBL,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);
    logic       lvbl_l;
    logic       vb_fall;
    logic [2:0] fall_cnt;
    logic       blink;
    logic       blink_nxt;

    assign vb_fall = lvbl_l & ~LVBL;

    // Flip once every eight frames
    assign blink_nxt = (downloading && vb_fall && fall_cnt == 3'd7) ? ~blink : blink;

    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            lvbl_l   <= 1'b0;
            fall_cnt <= 3'd0;
            blink    <= 1'b0;
            led      <= 1'b0;
        end else begin
            lvbl_l <= LVBL;
            blink  <= blink_nxt;
            if (!downloading) begin
                fall_cnt <= 3'd0;
            end else if (vb_fall) begin
                fall_cnt <= fall_cnt + 3'd1;
            end
            // OSD first, then download, then the game
            if (osd_shown) begin
                led <= 1'b1;
            end else if (downloading) begin
                led <= blink_nxt;
            end else begin
                led <= game_led[0];
            end
        end
    end

endmodule

// File: board_video.sv
////////////////////
// Bandwidth filter, sync alignment and 8-bit colour extension
////////////////////
`timescale 1ns/1ps

module board_video #(
    parameter int COLORW = 4
) (
    input  logic              clk_sys,
    input  logic              sys_rst_n,
    input  logic              pxl_cen,
    input  logic [COLORW-1:0] game_r,
    input  logic [COLORW-1:0] game_g,
    input  logic [COLORW-1:0] game_b,
    input  logic              LHBL,
    input  logic              LVBL,
    input  logic              hs,
    input  logic              vs,
    input  logic              bw_en,
    output logic [7:0]        scan2x_r,
    output logic [7:0]        scan2x_g,
    output logic [7:0]        scan2x_b,
    output logic              scan2x_hs,
    output logic              scan2x_vs,
    output logic              scan2x_de,
    output logic              scan2x_cen
);
    import board_pkg::*;

    // Narrow colour gains one bit from the filter sum
    localparam int CLROUTW = COLORW < 5 ? COLORW + 1 : COLORW;
    localparam int NCH     = 3;

    logic [COLORW-1:0]  cur  [NCH];
    logic [COLORW-1:0]  prev [NCH];
    logic [COLORW:0]    sum  [NCH];
    logic [COLORW:0]    pln  [NCH];
    logic [CLROUTW-1:0] flt  [NCH];
    logic [CLROUTW-1:0] spl  [NCH];
    logic               spl_hs;
    logic               spl_vs;
    logic               spl_de;
    logic               cen_l;

    assign cur[0] = game_r;
    assign cur[1] = game_g;
    assign cur[2] = game_b;

    assign scan2x_cen = pxl_cen;

    always_comb begin
        for (int i = 0; i < NCH; i++) begin
            sum[i] = {1'b0, cur[i]} + {1'b0, prev[i]};
            pln[i] = {cur[i], 1'b0};
            flt[i] = bw_en ? sum[i][COLORW -: CLROUTW] : pln[i][COLORW -: CLROUTW];
        end
    end

    // First stage takes the sample on the pixel enable
    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < NCH; i++) begin
                prev[i] <= '0;
                spl[i]  <= '0;
            end
            spl_hs <= 1'b0;
            spl_vs <= 1'b0;
            spl_de <= 1'b0;
            cen_l  <= 1'b0;
        end else begin
            cen_l <= pxl_cen;
            if (pxl_cen) begin
                for (int i = 0; i < NCH; i++) begin
                    prev[i] <= cur[i];
                    spl[i]  <= flt[i];
                end
                spl_hs <= hs;
                spl_vs <= vs;
                spl_de <= LHBL & LVBL;
            end
        end
    end

    // Output stage updates the cycle after each pixel enable
    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            scan2x_r  <= 8'd0;
            scan2x_g  <= 8'd0;
            scan2x_b  <= 8'd0;
            scan2x_hs <= 1'b0;
            scan2x_vs <= 1'b0;
            scan2x_de <= 1'b0;
        end else if (cen_l) begin
            scan2x_r  <= color_extend8(8'(spl[0]), CLROUTW);
            scan2x_g  <= color_extend8(8'(spl[1]), CLROUTW);
            scan2x_b  <= color_extend8(8'(spl[2]), CLROUTW);
            scan2x_hs <= spl_hs;
            scan2x_vs <= spl_vs;
            scan2x_de <= spl_de;
        end
    end

    a_out_hold: assert property (
        @(posedge clk_sys) disable iff (!sys_rst_n)
        !pxl_cen |-> ##2 $stable({scan2x_r, scan2x_g, scan2x_b,
                                  scan2x_hs, scan2x_vs, scan2x_de}));

endmodule

// File: board_top.sv
////////////////////
// Arcade board frame top level
////////////////////
`timescale 1ns/1ps

module board_top #(
    parameter int COLORW                 = 4,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1,
    parameter int GAME_RST_HOLD          = 16
) (
    input  logic                              clk_sys,
    input  logic                              rst_n,
    input  logic                              rst_req,
    input  logic                              downloading,
    output logic                              sys_rst_n,
    output logic                              game_rst_n,
    // Joysticks
    input  board_pkg::board_joy_t             board_joystick1,
    input  board_pkg::board_joy_t             board_joystick2,
    input  board_pkg::board_joy_t             board_joystick3,
    input  board_pkg::board_joy_t             board_joystick4,
    output board_pkg::game_joy_t              game_joystick1,
    output board_pkg::game_joy_t              game_joystick2,
    output board_pkg::game_joy_t              game_joystick3,
    output board_pkg::game_joy_t              game_joystick4,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_coin,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_start,
    output logic                              game_service,
    // DIP and OSD settings
    input  logic [31:0]                       status,
    input  logic [6:0]                        core_mod,
    output board_pkg::aspect_t                hdmi_arx,
    output board_pkg::aspect_t                hdmi_ary,
    output board_pkg::rotate_t                rotate,
    output logic                              enable_fm,
    output logic                              enable_psg,
    output logic                              dip_test,
    output logic                              dip_pause,
    output logic                              dip_flip,
    output board_pkg::fx_t                    dip_fxlevel,
    // LED
    input  logic                              osd_shown,
    input  logic [1:0]                        game_led,
    output logic                              led,
    // Base video
    input  logic [COLORW-1:0]                 game_r,
    input  logic [COLORW-1:0]                 game_g,
    input  logic [COLORW-1:0]                 game_b,
    input  logic                              LHBL,
    input  logic                              LVBL,
    input  logic                              hs,
    input  logic                              vs,
    input  logic                              pxl_cen,
    output logic [7:0]                        scan2x_r,
    output logic [7:0]                        scan2x_g,
    output logic [7:0]                        scan2x_b,
    output logic                              scan2x_hs,
    output logic                              scan2x_vs,
    output logic                              scan2x_de,
    output logic                              scan2x_cen
);
    logic soft_rst;
    logic game_pause;
    logic bw_en;

    // Upper effect level turns on the bandwidth filter
    assign bw_en = dip_fxlevel[1];

    // Port names match the local nets, so all blocks connect by name
    board_reset #(
        .GAME_RST_HOLD ( GAME_RST_HOLD )
    ) u_reset (.*);

    board_inputs #(
        .GAME_INPUTS_ACTIVE_LOW ( GAME_INPUTS_ACTIVE_LOW )
    ) u_inputs (.*);

    board_dip u_dip (.*);

    board_led u_led (.*);

    board_video #(
        .COLORW ( COLORW )
    ) u_video (.*);

endmodule

// File: tb_board.sv
////////////////////
// Board frame testbench with clock, reset, watchdog,
// compare tasks and a DIP stimulus table
////////////////////
`timescale 1ns/1ps

module tb_board;
    import board_pkg::*;

    localparam int COLORW     = 4;
    localparam bit ACTIVE_LOW = 1'b1;
    localparam int RST_HOLD   = 16;
    localparam int NROWS      = 8;
    localparam int NWORDS     = 8;
    localparam int NSAMPLES   = 12;
    localparam int LIMIT      = NROWS * 64 + 1000;
    // Status bits that carry a meaning
    localparam logic [31:0] USED_BITS = 32'h0000_34DE;

    typedef struct packed {
        logic [31:0] status;
        logic [6:0]  core;
        aspect_t     arx;
        aspect_t     ary;
        rotate_t     rot;
        logic        fm;
        logic        psg;
        logic        test;
        logic        pause;
        logic        flip;
        fx_t         fx;
    } dip_row_t;

    // status, core_mod, arx, ary, rotate, fm, psg, test, pause, flip, fxlevel
    localparam dip_row_t DIP_TABLE [NROWS] = '{
        '{32'h0000_0000, 7'h00, 12'd4,  12'd3, 2'b00, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0},
        '{32'h0000_0002, 7'h01, 12'd16, 12'd9, 2'b00, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0},
        '{32'h0000_0000, 7'h01, 12'd3,  12'd4, 2'b00, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0},
        '{32'h0000_0004, 7'h01, 12'd4,  12'd3, 2'b01, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0},
        '{32'h0000_2004, 7'h01, 12'd4,  12'd3, 2'b11, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 2'd0},
        '{32'h0000_1048, 7'h00, 12'd4,  12'd3, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 2'd1},
        '{32'h0000_0490, 7'h00, 12'd4,  12'd3, 2'b00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd2},
        '{32'h0000_201A, 7'h00, 12'd16, 12'd9, 2'b10, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 2'd3}
    };

    logic clk_sys = 1'b0;
    logic rst_n, rst_req, downloading, sys_rst_n, game_rst_n;
    board_joy_t board_joystick1, board_joystick2, board_joystick3, board_joystick4;
    game_joy_t game_joystick1, game_joystick2, game_joystick3, game_joystick4;
    logic [NUM_PLAYERS-1:0] game_coin, game_start;
    logic game_service;
    logic [31:0] status;
    logic [6:0] core_mod;
    aspect_t hdmi_arx, hdmi_ary;
    rotate_t rotate;
    logic enable_fm, enable_psg, dip_test, dip_pause, dip_flip;
    fx_t dip_fxlevel;
    logic osd_shown, led;
    logic [1:0] game_led;
    logic [COLORW-1:0] game_r, game_g, game_b;
    logic LHBL, LVBL, hs, vs, pxl_cen;
    logic [7:0] scan2x_r, scan2x_g, scan2x_b;
    logic scan2x_hs, scan2x_vs, scan2x_de, scan2x_cen;

    board_joy_t        words [NUM_PLAYERS];
    logic [COLORW-1:0] smp [3];
    logic [COLORW-1:0] prv [3];
    logic [7:0]        exp_c [3];
    logic              exp_hs, exp_vs, exp_de, have_exp, blink_exp;
    logic [3:0]        sync_rnd;

    board_top #(
        .COLORW                 ( COLORW     ),
        .GAME_INPUTS_ACTIVE_LOW ( ACTIVE_LOW ),
        .GAME_RST_HOLD          ( RST_HOLD   )
    ) UUT (.*);

    always #4 clk_sys = ~clk_sys;

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_joy(input string name, input game_joy_t got, input game_joy_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_btns(input string name, input logic [NUM_PLAYERS-1:0] got,
                              input logic [NUM_PLAYERS-1:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_aspect(input string name, input aspect_t got, input aspect_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_rotate(input string name, input rotate_t got, input rotate_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_fx(input string name, input fx_t got, input fx_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_color(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // Call on the negedge after the last edge that saw a reset cause
    task automatic check_hold(input string name);
        int n;
        n = 0;
        while (game_rst_n !== 1'b1) begin
            @(negedge clk_sys);
            n++;
        end
        check_cycles(name, n, RST_HOLD);
    endtask

    // Press and release a player 1 button and stop on the negedge two edges later
    task automatic tap_button(input int idx);
        @(posedge clk_sys);
        board_joystick1 <= board_joy_t'(1 << idx);
        @(posedge clk_sys);
        board_joystick1 <= '0;
        @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    task automatic drive_words();
        board_joystick1 <= words[0];
        board_joystick2 <= words[1];
        board_joystick3 <= words[2];
        board_joystick4 <= words[3];
    endtask

    function automatic game_joy_t joy_expect(input board_joy_t w, input logic locked);
        if (locked) begin
            return {JOYW{ACTIVE_LOW}};
        end
        return ACTIVE_LOW ? ~w[JOYW-1:0] : w[JOYW-1:0];
    endfunction

    task automatic check_game_side(input logic locked);
        logic [NUM_PLAYERS-1:0] coin_e;
        logic [NUM_PLAYERS-1:0] start_e;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            coin_e[i]  = locked ? ACTIVE_LOW : words[i][JOY_COIN_BIT] ^ ACTIVE_LOW;
            start_e[i] = locked ? ACTIVE_LOW : words[i][JOY_START_BIT] ^ ACTIVE_LOW;
        end
        check_joy("game_joystick1", game_joystick1, joy_expect(words[0], locked));
        check_joy("game_joystick2", game_joystick2, joy_expect(words[1], locked));
        check_joy("game_joystick3", game_joystick3, joy_expect(words[2], locked));
        check_joy("game_joystick4", game_joystick4, joy_expect(words[3], locked));
        check_btns("game_coin", game_coin, coin_e);
        check_btns("game_start", game_start, start_e);
        check_bit("game_service", game_service,
                  locked ? ACTIVE_LOW : words[0][JOY_SERVICE_BIT] ^ ACTIVE_LOW);
    endtask

    task automatic check_dip_row(input dip_row_t row);
        check_aspect("hdmi_arx", hdmi_arx, row.arx);
        check_aspect("hdmi_ary", hdmi_ary, row.ary);
        check_rotate("rotate", rotate, row.rot);
        check_bit("enable_fm", enable_fm, row.fm);
        check_bit("enable_psg", enable_psg, row.psg);
        check_bit("dip_test", dip_test, row.test);
        check_bit("dip_pause", dip_pause, row.pause);
        check_bit("dip_flip", dip_flip, row.flip);
        check_fx("dip_fxlevel", dip_fxlevel, row.fx);
    endtask

    // 4-bit colour grows to a 5-bit internal value whose top bits then fill below
    function automatic logic [7:0] expect_color(input logic [COLORW-1:0] c,
                                                input logic [COLORW-1:0] p, input logic bw);
        logic [COLORW:0] v;
        if (bw) begin
            v = {1'b0, c} + {1'b0, p};
        end else begin
            v = {c, 1'b0};
        end
        return {v, v[COLORW -: 3]};
    endfunction

    task automatic check_video(input logic cen_exp);
        check_color("scan2x_r", scan2x_r, exp_c[0]);
        check_color("scan2x_g", scan2x_g, exp_c[1]);
        check_color("scan2x_b", scan2x_b, exp_c[2]);
        check_bit("scan2x_hs", scan2x_hs, exp_hs);
        check_bit("scan2x_vs", scan2x_vs, exp_vs);
        check_bit("scan2x_de", scan2x_de, exp_de);
        check_bit("scan2x_cen", scan2x_cen, cen_exp);
    endtask

    // One pass of samples with pxl_cen high every other cycle
    task automatic run_video(input logic bw);
        @(posedge clk_sys);
        status <= bw ? 32'h0000_0010 : 32'h0000_0000;
        repeat (2) @(posedge clk_sys);
        have_exp = 1'b0;
        for (int n = 0; n < NSAMPLES; n++) begin
            @(posedge clk_sys);
            for (int i = 0; i < 3; i++) begin
                smp[i] = COLORW'($urandom);
            end
            sync_rnd = 4'($urandom);
            pxl_cen <= 1'b1;
            game_r  <= smp[0];
            game_g  <= smp[1];
            game_b  <= smp[2];
            {LHBL, LVBL, hs, vs} <= sync_rnd;
            if (have_exp) begin
                @(negedge clk_sys);
                check_video(1'b1);
            end
            for (int i = 0; i < 3; i++) begin
                exp_c[i] = expect_color(smp[i], prv[i], bw);
                prv[i]   = smp[i];
            end
            exp_de   = sync_rnd[3] & sync_rnd[2];
            exp_hs   = sync_rnd[1];
            exp_vs   = sync_rnd[0];
            have_exp = 1'b1;
            @(posedge clk_sys);
            pxl_cen <= 1'b0;
        end
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_video(1'b0);
    endtask

    initial begin
        repeat (LIMIT) @(posedge clk_sys);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        stop_run();
    end

    initial begin
        void'($urandom(39689));
        rst_n = 1'b0;
        rst_req = 1'b0;
        downloading = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_joystick3 = '0;
        board_joystick4 = '0;
        status = '0;
        core_mod = '0;
        osd_shown = 1'b0;
        game_led = 2'b00;
        game_r = '0;
        game_g = '0;
        game_b = '0;
        {LHBL, LVBL, hs, vs} = 4'b1100;
        pxl_cen = 1'b0;
        for (int i = 0; i < 3; i++) begin
            prv[i] = '0;
        end

        // Reset release and game reset hold
        repeat (10) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);
        check_bit("sys_rst_n", sys_rst_n, 1'b0);
        @(negedge clk_sys);
        check_bit("sys_rst_n", sys_rst_n, 1'b0);
        @(negedge clk_sys);
        check_bit("sys_rst_n", sys_rst_n, 1'b1);
        check_hold("game_rst_n hold after reset");
        @(posedge clk_sys);
        downloading <= 1'b1;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("game_rst_n", game_rst_n, 1'b0);
        @(posedge clk_sys);
        downloading <= 1'b0;
        @(negedge clk_sys);
        check_hold("game_rst_n hold after download");
        @(posedge clk_sys);
        status <= 32'h0000_2000;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("game_rst_n", game_rst_n, 1'b0);
        check_hold("game_rst_n hold after flip");
        tap_button(JOY_RESET_BIT);
        check_bit("game_rst_n", game_rst_n, 1'b0);
        check_hold("game_rst_n hold after soft reset");

        // Joystick mapping with the last word applied while downloading
        @(posedge clk_sys);
        status <= '0;
        for (int k = 0; k <= NWORDS; k++) begin
            @(posedge clk_sys);
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                words[i] = board_joy_t'($urandom);
            end
            words[0][JOY_RESET_BIT] = 1'b0;
            words[0][JOY_PAUSE_BIT] = 1'b0;
            drive_words();
            downloading <= (k == NWORDS);
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_game_side(k == NWORDS);
        end
        @(posedge clk_sys);
        downloading <= 1'b0;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            words[i] = '0;
        end
        drive_words();
        tap_button(JOY_PAUSE_BIT);
        check_bit("dip_pause", dip_pause, 1'b1);
        tap_button(JOY_PAUSE_BIT);
        check_bit("dip_pause", dip_pause, 1'b0);

        // DIP table with random fill on the spare bits
        for (int r = 0; r < NROWS; r++) begin
            @(posedge clk_sys);
            status   <= DIP_TABLE[r].status | ($urandom & ~USED_BITS);
            core_mod <= DIP_TABLE[r].core | (7'($urandom) & 7'h7E);
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_dip_row(DIP_TABLE[r]);
        end

        // LED source priority and the blink while downloading
        @(posedge clk_sys);
        osd_shown <= 1'b1;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("led", led, 1'b1);
        @(posedge clk_sys);
        osd_shown <= 1'b0;
        game_led  <= 2'b01;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("led", led, 1'b1);
        @(posedge clk_sys);
        game_led <= 2'b10;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("led", led, 1'b0);
        @(posedge clk_sys);
        downloading <= 1'b1;
        game_led    <= 2'b11;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("led", led, 1'b0);
        blink_exp = 1'b0;
        for (int k = 1; k <= 16; k++) begin
            @(posedge clk_sys);
            LVBL <= 1'b0;
            @(posedge clk_sys);
            @(negedge clk_sys);
            if (k % 8 == 0) begin
                blink_exp = ~blink_exp;
            end
            check_bit("led", led, blink_exp);
            @(posedge clk_sys);
            LVBL <= 1'b1;
            @(posedge clk_sys);
        end
        @(posedge clk_sys);
        downloading <= 1'b0;

        // Video path in plain and then filtered mode
        run_video(1'b0);
        run_video(1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: sim.f
board_pkg.sv
board_reset.sv
board_inputs.sv
board_dip.sv
board_led.sv
board_video.sv
board_top.sv
tb_board.sv

// File: Bender.yml
package:
  name: board_frame

sources:
  - board_pkg.sv
  - board_reset.sv
  - board_inputs.sv
  - board_dip.sv
  - board_led.sv
  - board_video.sv
  - board_top.sv
  - target: simulation
    files:
      - tb_board.sv
